/* common/pipeConsts.svh */
/* pipeline constants
   widths, reset vector and the MIPS opcode and funct codes of the supported subset */
`ifndef PIPE_CONSTS_SVH
`define PIPE_CONSTS_SVH

`define DATA_W   32
`define REG_W    5
`define RESET_PC 32'h0000_0000

// primary opcodes
`define OP_RTYPE 6'h00
`define OP_J     6'h02
`define OP_BEQ   6'h04
`define OP_BNE   6'h05
`define OP_ADDIU 6'h09
`define OP_LW    6'h23
`define OP_SW    6'h2b

// funct codes under OP_RTYPE
`define FN_JALR  6'h09
`define FN_ADDU  6'h21
`define FN_SUBU  6'h23

`endif

/* common/pipePkg.sv */
/* pipeline types
   ALU operation codes and the payload structs held by each stage register */
`include "pipeConsts.svh"

package pipePkg;

	// passB forwards operand B untouched, used for the jalr link value
	typedef enum logic [1:0] {
		aluAdd   = 2'd0,
		aluSub   = 2'd1,
		aluPassB = 2'd2
	} aluOpE;

	// fetch to decode
	typedef struct packed {
		logic [`DATA_W-1:0] instr;
		logic [`DATA_W-1:0] pcPlus4;
	} fdT;

	// decode to execute
	typedef struct packed {
		logic               regWrite;
		logic               memToReg;
		logic               memWrite;
		logic               aluSrc;
		aluOpE              aluOp;
		logic [`REG_W-1:0]  rs;
		logic [`REG_W-1:0]  rt;
		logic [`REG_W-1:0]  writeReg;
		logic [`DATA_W-1:0] rd1;
		logic [`DATA_W-1:0] rd2;
		logic [`DATA_W-1:0] imm;
		logic [`DATA_W-1:0] link;
	} deT;

	// execute to memory
	typedef struct packed {
		logic               regWrite;
		logic               memToReg;
		logic               memWrite;
		logic [`REG_W-1:0]  writeReg;
		logic [`DATA_W-1:0] aluOut;
		logic [`DATA_W-1:0] writeData;
	} emT;

	// memory to writeback
	typedef struct packed {
		logic               regWrite;
		logic [`REG_W-1:0]  writeReg;
		logic [`DATA_W-1:0] result;
	} mwT;

endpackage

/* src/pipeReg.sv */
/* pipeline stage register
   holds on stall, clears to a bubble on flush, one instance per stage boundary */
`timescale 1ns/100ps

module pipeReg
	import pipePkg::*;
#(
	parameter type payloadT = deT
) (
	input  logic    clk,
	input  logic    arstN,
	input  logic    stall,
	input  logic    flush,
	input  payloadT d,
	output payloadT q
);

	// all-zero payload is a bubble, regWrite and memWrite both low
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			q <= '0;
		end else if (stall) begin
			q <= q;
		end else if (flush) begin
			q <= '0;
		end else begin
			q <= d;
		end
	end

	// hazard control must never ask a stage to hold and drop its contents at once
	aStallFlush: assert property (@(posedge clk) disable iff (!arstN) !(stall && flush))
		else $error("pipeReg: stall and flush high together");

endmodule

/* src/regFile.sv */
/* register file
   32 x 32 bits, two combinational read ports with write-through, one write port */
`timescale 1ns/100ps
`include "pipeConsts.svh"

module regFile (
	input  logic               clk,
	input  logic               arstN,
	input  logic [`REG_W-1:0]  ra1,
	input  logic [`REG_W-1:0]  ra2,
	output logic [`DATA_W-1:0] rd1,
	output logic [`DATA_W-1:0] rd2,
	input  logic               we,
	input  logic [`REG_W-1:0]  wa,
	input  logic [`DATA_W-1:0] wd
);

	// no storage behind register 0
	logic [`DATA_W-1:0] rf [1:(2**`REG_W)-1];

	always_ff @(posedge clk) begin
		if (we && (wa != '0)) begin
			rf[wa] <= wd;
		end
	end

	// same-cycle write is passed straight to the reader, so W to D needs no bypass
	assign rd1 = (ra1 == '0) ? '0 : ((we && (wa == ra1)) ? wd : rf[ra1]);
	assign rd2 = (ra2 == '0) ? '0 : ((we && (wa == ra2)) ? wd : rf[ra2]);

	// a word written one cycle ago reads back unless a newer write to it bypasses the array
	aReadBack: assert property (@(posedge clk) disable iff (!arstN)
		(we && (wa != '0)) |=>
		((ra1 != $past(wa)) || (we && (wa == ra1)) || (rd1 == $past(wd))))
		else $error("regFile: written word not read back");

endmodule

/* decode/decodeStage.sv */
/* decode stage
   instruction decoder, forwarded branch comparator and next-PC target selection */
`timescale 1ns/100ps
`include "pipeConsts.svh"

module decodeStage
	import pipePkg::*;
(
	input  logic [`DATA_W-1:0] instrD,
	input  logic [`DATA_W-1:0] pcPlus4D,
	input  logic [`DATA_W-1:0] rd1,
	input  logic [`DATA_W-1:0] rd2,
	input  logic [`DATA_W-1:0] aluOutM,
	input  logic               forwardAD,
	input  logic               forwardBD,
	output logic [`REG_W-1:0]  rsD,
	output logic [`REG_W-1:0]  rtD,
	output logic               branchD,
	output logic               jumpD,
	output logic               jalrD,
	output logic               brTakenD,
	output logic [`DATA_W-1:0] pcNext,
	output logic               regWriteD,
	output logic               memToRegD,
	output logic               memWriteD,
	output logic               aluSrcD,
	output aluOpE              aluOpD,
	output logic [`REG_W-1:0]  writeRegD,
	output logic [`DATA_W-1:0] immD,
	output logic [`DATA_W-1:0] linkD
);

	logic [5:0]         opcode;
	logic [5:0]         funct;
	logic [`REG_W-1:0]  rdD;
	logic [`DATA_W-1:0] srcAD;
	logic [`DATA_W-1:0] srcBD;
	logic [`DATA_W-1:0] branchTarget;
	logic [`DATA_W-1:0] jumpTarget;

	// instruction fields
	assign opcode = instrD[31:26];
	assign funct  = instrD[5:0];
	assign rsD    = instrD[25:21];
	assign rtD    = instrD[20:16];
	assign rdD    = instrD[15:11];
	assign immD   = {{(`DATA_W-16){instrD[15]}}, instrD[15:0]};
	assign linkD  = pcPlus4D;

	// control decode, a zero word (bubble) decodes to nothing
	always_comb begin
		regWriteD = 1'b0;
		memToRegD = 1'b0;
		memWriteD = 1'b0;
		aluSrcD   = 1'b0;
		aluOpD    = aluAdd;
		branchD   = 1'b0;
		jumpD     = 1'b0;
		jalrD     = 1'b0;
		writeRegD = rtD;
		case (opcode)
			`OP_RTYPE: begin
				writeRegD = rdD;
				case (funct)
					`FN_ADDU: begin
						regWriteD = 1'b1;
					end
					`FN_SUBU: begin
						regWriteD = 1'b1;
						aluOpD    = aluSub;
					end
					`FN_JALR: begin
						// link to rd, value goes down the pipe through ALU operand B
						regWriteD = 1'b1;
						aluOpD    = aluPassB;
						jalrD     = 1'b1;
					end
					default: begin
						regWriteD = 1'b0;
					end
				endcase
			end
			`OP_ADDIU: begin
				regWriteD = 1'b1;
				aluSrcD   = 1'b1;
			end
			`OP_LW: begin
				regWriteD = 1'b1;
				memToRegD = 1'b1;
				aluSrcD   = 1'b1;
			end
			`OP_SW: begin
				memWriteD = 1'b1;
				aluSrcD   = 1'b1;
			end
			`OP_BEQ, `OP_BNE: begin
				branchD = 1'b1;
			end
			`OP_J: begin
				jumpD = 1'b1;
			end
			default: begin
				regWriteD = 1'b0;
			end
		endcase
	end

	// comparator operands, an ALU result still in M is picked up here
	assign srcAD = forwardAD ? aluOutM : rd1;
	assign srcBD = forwardBD ? aluOutM : rd2;

	assign brTakenD = branchD && ((opcode == `OP_BNE) ? (srcAD != srcBD) : (srcAD == srcBD));

	assign branchTarget = pcPlus4D + {immD[`DATA_W-3:0], 2'b00};
	assign jumpTarget   = {pcPlus4D[31:28], instrD[25:0], 2'b00};

	// redirect target; falls back to pcPlus4D when nothing redirects
	always_comb begin
		if (jalrD) begin
			pcNext = srcAD;
		end else if (jumpD) begin
			pcNext = jumpTarget;
		end else if (brTakenD) begin
			pcNext = branchTarget;
		end else begin
			pcNext = pcPlus4D;
		end
	end

endmodule

/* decode/hazardUnit.sv */
/* hazard unit
   bypass selection for D and E, load-use and branch stalls, memory waits and flushes */
`timescale 1ns/100ps
`include "pipeConsts.svh"

module hazardUnit (
	input  logic              Iwait,
	input  logic              Dwait,
	input  logic              branchD,
	input  logic              jumpD,
	input  logic              jalrD,
	input  logic              brTakenD,
	input  logic              memToRegE,
	input  logic              regWriteE,
	input  logic              memToRegM,
	input  logic              regWriteM,
	input  logic              memWriteM,
	input  logic              regWriteW,
	input  logic [`REG_W-1:0] rsD,
	input  logic [`REG_W-1:0] rtD,
	input  logic [`REG_W-1:0] rsE,
	input  logic [`REG_W-1:0] rtE,
	input  logic [`REG_W-1:0] writeRegE,
	input  logic [`REG_W-1:0] writeRegM,
	input  logic [`REG_W-1:0] writeRegW,
	output logic              forwardAD,
	output logic              forwardBD,
	output logic [1:0]        forwardAE,
	output logic [1:0]        forwardBE,
	output logic              stallF,
	output logic              stallD,
	output logic              stallE,
	output logic              stallM,
	output logic              stallW,
	output logic              flushD,
	output logic              flushE,
	output logic              memAccessM
);

	logic lwStall;
	logic branchStall;
	logic memStall;
	logic matchE;
	logic matchM;

	// E operand bypass, 10 takes aluOutM, 01 takes resultW, M is younger so it wins
	always_comb begin
		if ((rsE != '0) && (rsE == writeRegM) && regWriteM) begin
			forwardAE = 2'b10;
		end else if ((rsE != '0) && (rsE == writeRegW) && regWriteW) begin
			forwardAE = 2'b01;
		end else begin
			forwardAE = 2'b00;
		end
		if ((rtE != '0) && (rtE == writeRegM) && regWriteM) begin
			forwardBE = 2'b10;
		end else if ((rtE != '0) && (rtE == writeRegW) && regWriteW) begin
			forwardBE = 2'b01;
		end else begin
			forwardBE = 2'b00;
		end
	end

	// comparator bypass from M only; W reaches D through the register file
	assign forwardAD = (rsD != '0) && (rsD == writeRegM) && regWriteM;
	assign forwardBD = (rtD != '0) && (rtD == writeRegM) && regWriteM;

	// D sources against the E and M destinations, register 0 never matches
	assign matchE = (writeRegE != '0) && ((writeRegE == rsD) || (writeRegE == rtD));
	assign matchM = (writeRegM != '0) && ((writeRegM == rsD) || (writeRegM == rtD));

	always_comb begin
		// data memory wait only counts with an access sitting in M
		memAccessM = memToRegM | memWriteM;
		memStall   = Dwait & memAccessM;

		// load in E feeding D, one bubble
		lwStall = memToRegE & matchE;

		// branch or jalr operands must be at least in M as an ALU result
		branchStall = (branchD | jalrD) & ((regWriteE & matchE) | (memToRegM & matchM));

		// memory wait freezes everything
		stallE = memStall;
		stallM = memStall;
		stallW = memStall;

		// fetch wait behaves like a load-use stall
		stallF = lwStall | branchStall | memStall | Iwait;
		stallD = stallF;

		// redirect drops the wrong-path fetch, but not while D itself is held
		flushD = (brTakenD | jumpD | jalrD) & ~stallD;
		flushE = (lwStall | branchStall | Iwait) & ~memStall;
	end

endmodule

/* src/executeStage.sv */
/* execute stage
   operand bypass from M and W, immediate and link selection, and the ALU */
`timescale 1ns/100ps
`include "pipeConsts.svh"

module executeStage
	import pipePkg::*;
(
	input  logic [`DATA_W-1:0] rd1E,
	input  logic [`DATA_W-1:0] rd2E,
	input  logic [`DATA_W-1:0] immE,
	input  logic [`DATA_W-1:0] linkE,
	input  logic               aluSrcE,
	input  pipePkg::aluOpE     aluOpE,
	input  logic [1:0]         forwardAE,
	input  logic [1:0]         forwardBE,
	input  logic [`DATA_W-1:0] aluOutM,
	input  logic [`DATA_W-1:0] resultW,
	output logic [`DATA_W-1:0] aluOutE,
	output logic [`DATA_W-1:0] writeDataE
);

	logic [`DATA_W-1:0] srcAE;
	logic [`DATA_W-1:0] srcBE;

	always_comb begin
		// bypassed register operands
		case (forwardAE)
			2'b10:   srcAE = aluOutM;
			2'b01:   srcAE = resultW;
			default: srcAE = rd1E;
		endcase
		case (forwardBE)
			2'b10:   writeDataE = aluOutM;
			2'b01:   writeDataE = resultW;
			default: writeDataE = rd2E;
		endcase

		// B is the link for jalr, the immediate for I-type, else the register
		if (aluOpE == aluPassB) begin
			srcBE = linkE;
		end else if (aluSrcE) begin
			srcBE = immE;
		end else begin
			srcBE = writeDataE;
		end

		case (aluOpE)
			aluAdd:  aluOutE = srcAE + srcBE;
			aluSub:  aluOutE = srcAE - srcBE;
			default: aluOutE = srcBE;
		endcase
	end

endmodule

/* src/pipelineTop.sv */
/* five-stage pipeline top
   PC, stage registers, decode, execute, hazard control and the memory ports */
`timescale 1ns/100ps
`include "pipeConsts.svh"

module pipelineTop
	import pipePkg::*;
(
	input  logic               clk,
	input  logic               arstN,
	output logic [`DATA_W-1:0] iAddr,
	input  logic [`DATA_W-1:0] iData,
	input  logic               Iwait,
	output logic [`DATA_W-1:0] dAddr,
	output logic [`DATA_W-1:0] dWdata,
	input  logic [`DATA_W-1:0] dRdata,
	output logic               dRead,
	output logic               dWrite,
	input  logic               Dwait,
	output logic               wbEn,
	output logic [`REG_W-1:0]  wbReg,
	output logic [`DATA_W-1:0] wbData
);

	logic [`DATA_W-1:0] pcF;
	logic [`DATA_W-1:0] pcPlus4F;
	fdT fdF, fdD;
	deT deD, deE;
	emT emE, emM;
	mwT mwM, mwW;

	logic stallF, stallD, stallE, stallM, stallW;
	logic flushD, flushE, memAccessM;
	logic forwardAD, forwardBD;
	logic [1:0] forwardAE, forwardBE;

	logic [`REG_W-1:0]  rsD, rtD, writeRegD;
	logic [`DATA_W-1:0] rd1D, rd2D, pcNextD, immD, linkD;
	logic branchD, jumpD, jalrD, brTakenD;
	logic regWriteD, memToRegD, memWriteD, aluSrcD;
	aluOpE aluOpD;
	logic [`DATA_W-1:0] aluOutE, writeDataE;

	// fetch, PC takes the decode redirect or moves on by one word
	assign pcPlus4F = pcF + 32'd4;
	assign iAddr    = pcF;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pcF <= `RESET_PC;
		end else if (!stallF) begin
			pcF <= (brTakenD | jumpD | jalrD) ? pcNextD : pcPlus4F;
		end
	end

	assign fdF.instr   = iData;
	assign fdF.pcPlus4 = pcPlus4F;

	pipeReg #(.payloadT(fdT)) FD (
		.clk(clk), .arstN(arstN), .stall(stallD), .flush(flushD), .d(fdF), .q(fdD)
	);

	// decode
	regFile rf (
		.clk(clk), .arstN(arstN), .ra1(rsD), .ra2(rtD), .rd1(rd1D), .rd2(rd2D),
		.we(wbEn), .wa(mwW.writeReg), .wd(mwW.result)
	);

	decodeStage dec (
		.instrD(fdD.instr), .pcPlus4D(fdD.pcPlus4), .rd1(rd1D), .rd2(rd2D),
		.aluOutM(emM.aluOut), .forwardAD(forwardAD), .forwardBD(forwardBD),
		.rsD(rsD), .rtD(rtD), .branchD(branchD), .jumpD(jumpD), .jalrD(jalrD),
		.brTakenD(brTakenD), .pcNext(pcNextD), .regWriteD(regWriteD),
		.memToRegD(memToRegD), .memWriteD(memWriteD), .aluSrcD(aluSrcD),
		.aluOpD(aluOpD), .writeRegD(writeRegD), .immD(immD), .linkD(linkD)
	);

	always_comb begin
		deD.regWrite = regWriteD;
		deD.memToReg = memToRegD;
		deD.memWrite = memWriteD;
		deD.aluSrc   = aluSrcD;
		deD.aluOp    = aluOpD;
		deD.rs       = rsD;
		deD.rt       = rtD;
		deD.writeReg = writeRegD;
		deD.rd1      = rd1D;
		deD.rd2      = rd2D;
		deD.imm      = immD;
		deD.link     = linkD;
	end

	pipeReg #(.payloadT(deT)) DE (
		.clk(clk), .arstN(arstN), .stall(stallE), .flush(flushE), .d(deD), .q(deE)
	);

	// execute
	executeStage ex (
		.rd1E(deE.rd1), .rd2E(deE.rd2), .immE(deE.imm), .linkE(deE.link),
		.aluSrcE(deE.aluSrc), .aluOpE(deE.aluOp), .forwardAE(forwardAE),
		.forwardBE(forwardBE), .aluOutM(emM.aluOut), .resultW(mwW.result),
		.aluOutE(aluOutE), .writeDataE(writeDataE)
	);

	assign emE = '{regWrite: deE.regWrite, memToReg: deE.memToReg, memWrite: deE.memWrite,
		writeReg: deE.writeReg, aluOut: aluOutE, writeData: writeDataE};

	pipeReg #(.payloadT(emT)) EM (
		.clk(clk), .arstN(arstN), .stall(stallM), .flush(1'b0), .d(emE), .q(emM)
	);

	// memory, strobes stay level while Dwait holds M
	assign dAddr  = emM.aluOut;
	assign dWdata = emM.writeData;
	assign dRead  = memAccessM & emM.memToReg;
	assign dWrite = memAccessM & emM.memWrite;

	assign mwM.regWrite = emM.regWrite;
	assign mwM.writeReg = emM.writeReg;
	assign mwM.result   = emM.memToReg ? dRdata : emM.aluOut;

	pipeReg #(.payloadT(mwT)) MW (
		.clk(clk), .arstN(arstN), .stall(stallW), .flush(1'b0), .d(mwM), .q(mwW)
	);

	// writeback, one wbEn pulse per retiring write even while W is held
	assign wbEn   = mwW.regWrite & ~stallW;
	assign wbReg  = mwW.writeReg;
	assign wbData = mwW.result;

	hazardUnit hz (
		.Iwait(Iwait), .Dwait(Dwait), .branchD(branchD), .jumpD(jumpD), .jalrD(jalrD),
		.brTakenD(brTakenD), .memToRegE(deE.memToReg), .regWriteE(deE.regWrite),
		.memToRegM(emM.memToReg), .regWriteM(emM.regWrite), .memWriteM(emM.memWrite),
		.regWriteW(mwW.regWrite), .rsD(rsD), .rtD(rtD), .rsE(deE.rs), .rtE(deE.rt),
		.writeRegE(deE.writeReg), .writeRegM(emM.writeReg), .writeRegW(mwW.writeReg),
		.forwardAD(forwardAD), .forwardBD(forwardBD), .forwardAE(forwardAE),
		.forwardBE(forwardBE), .stallF(stallF), .stallD(stallD), .stallE(stallE),
		.stallM(stallM), .stallW(stallW), .flushD(flushD), .flushE(flushE),
		.memAccessM(memAccessM)
	);

endmodule

/* dv/tbPipeline.sv */
/* pipeline testbench
   memory models with random waits, a fixed program, writeback and store checks */
`timescale 1ns/100ps
`include "pipeConsts.svh"

module tbPipeline;

	// two passes of about 32 instructions, at worst ~40 cycles each with waits
	localparam int maxCycles = 3000;
	localparam int numWb = 15;
	localparam int numSt = 3;
	localparam int numLd = 3;

	logic clk = 1'b0;
	logic arstN = 1'b0;
	logic [`DATA_W-1:0] iAddr, dAddr, dWdata, wbData;
	logic [`DATA_W-1:0] iData = '0;
	logic [`DATA_W-1:0] dRdata = '0;
	logic Iwait = 1'b0;
	logic Dwait = 1'b0;
	logic dRead, dWrite, wbEn;
	logic [`REG_W-1:0] wbReg;
	logic [`DATA_W-1:0] rom [0:31];
	logic [`DATA_W-1:0] ram [0:63];
	logic [`REG_W-1:0] expReg [0:numWb-1];
	logic [`DATA_W-1:0] expData [0:numWb-1];
	logic [`DATA_W-1:0] expStAddr [0:numSt-1];
	logic [`DATA_W-1:0] expStData [0:numSt-1];
	int wbIdx, stIdx, ldCnt, cycles, errors, passed, failed;
	integer seed = 52;
	logic waitsOn = 1'b0;

	pipelineTop DUT (.*);

	initial begin
		forever #10 clk = ~clk;
	end

	// fill word depends on the whole word address
	function automatic logic [`DATA_W-1:0] fillWord(int a);
		return a * 32'h9E37_79B9 + 32'h0000_1357;
	endfunction

	function automatic logic [31:0] encR(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
		logic [5:0] fn);
		return {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] encI(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// memory models answer from the falling edge, waits come from the seeded stream
	always @(negedge clk) begin
		iData <= rom[iAddr[6:2]];
		// read data only while dRead is up
		dRdata <= dRead ? ram[dAddr[7:2]] : '1;
		Iwait <= waitsOn && (($random(seed) & 3) == 0);
		Dwait <= waitsOn && (($random(seed) & 3) == 0);
	end

	always @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 64; i++) begin
				ram[i] <= fillWord(i);
			end
			stIdx <= 0;
		end else if (dWrite && !Dwait) begin
			ram[dAddr[7:2]] <= dWdata;
			stIdx <= stIdx + 1;
		end
	end

	// completed data reads, a wait cycle does not count
	always @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			ldCnt <= 0;
		end else if (dRead && !Dwait) begin
			ldCnt <= ldCnt + 1;
		end
	end

	always @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wbIdx <= 0;
		end else if (wbEn && (wbReg != '0)) begin
			wbIdx <= wbIdx + 1;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
	end

	// in-order writeback results, register 0 targets carry no architectural result
	aWriteback: assert property (@(posedge clk) disable iff (!arstN)
		(wbEn && (wbReg != '0)) |->
		((wbIdx < numWb) && (wbReg == expReg[wbIdx]) && (wbData == expData[wbIdx])))
		else begin
			$display("FAIL %0t: writeback %0d got r%0d=%h", $time, wbIdx, wbReg, wbData);
			errors++;
		end

	aStore: assert property (@(posedge clk) disable iff (!arstN)
		(dWrite && !Dwait) |->
		((stIdx < numSt) && (dAddr == expStAddr[stIdx]) && (dWdata == expStData[stIdx])))
		else begin
			$display("FAIL %0t: store %0d got [%h]=%h", $time, stIdx, dAddr, dWdata);
			errors++;
		end

	initial begin
		while (cycles < maxCycles) @(posedge clk);
		$display("ERROR: the run timed out after %0d cycles", maxCycles);
		$display("FAIL: see errors above");
		$finish;
	end

	// waits until the region's results are in, then reports it
	task automatic finishRegion(string name, int wbTarget, int stTarget, int pass);
		int errStart;
		errStart = errors;
		while ((wbIdx < wbTarget) || (stIdx < stTarget)) @(posedge clk);
		if (stTarget == numSt) begin
			repeat (10) @(posedge clk);
			assert ((ram[1] == 32'h0000_135C) && (ram[2] == 32'd92) && (ram[3] == 32'd79))
				else begin
					$display("FAIL %0t: data memory words 1..3 wrong after the run", $time);
					errors++;
				end
			assert (ldCnt == numLd)
				else begin
					$display("FAIL %0t: %0d data reads completed, expected %0d", $time,
						ldCnt, numLd);
					errors++;
				end
		end
		if (errors == errStart) begin
			passed++;
			$display("test %s (waits %0d): ok", name, pass);
		end else begin
			failed++;
			$display("test %s (waits %0d): failed", name, pass);
		end
	endtask

	initial begin
		cycles = 0;
		errors = 0;
		passed = 0;
		failed = 0;
		for (int i = 0; i < 32; i++) begin
			rom[i] = '0;
		end
		rom[0]  = encI(`OP_ADDIU, 0, 1, 16'd5);
		rom[1]  = encI(`OP_ADDIU, 1, 2, 16'd3);
		rom[2]  = encR(1, 2, 3, `FN_ADDU);
		rom[3]  = encR(3, 1, 4, `FN_SUBU);
		rom[4]  = encR(4, 4, 0, `FN_ADDU);
		rom[5]  = encR(0, 4, 5, `FN_ADDU);
		rom[6]  = encI(`OP_LW, 0, 6, 16'd0);
		rom[7]  = encR(6, 1, 7, `FN_ADDU);
		rom[8]  = encI(`OP_SW, 0, 7, 16'd4);
		rom[9]  = encI(`OP_LW, 0, 8, 16'd4);
		rom[10] = encI(`OP_BEQ, 8, 7, 16'd1);
		rom[11] = encI(`OP_ADDIU, 0, 9, 16'd99);
		rom[12] = encI(`OP_ADDIU, 0, 9, 16'd7);
		rom[13] = encI(`OP_BNE, 9, 1, 16'd1);
		rom[14] = encI(`OP_ADDIU, 0, 10, 16'd99);
		rom[15] = encI(`OP_ADDIU, 9, 10, 16'hFFFE);
		rom[16] = encI(`OP_BNE, 10, 1, 16'd1);
		rom[17] = encI(`OP_ADDIU, 0, 11, 16'd1);
		rom[18] = encI(`OP_BEQ, 11, 0, 16'd1);
		rom[19] = {`OP_J, 26'd21};
		rom[20] = encI(`OP_ADDIU, 0, 12, 16'd99);
		rom[21] = encI(`OP_ADDIU, 0, 12, 16'd104);
		rom[22] = encR(12, 0, 13, `FN_JALR);
		rom[23] = encI(`OP_ADDIU, 0, 14, 16'd99);
		rom[24] = encI(`OP_ADDIU, 0, 14, 16'd99);
		rom[25] = encI(`OP_ADDIU, 0, 14, 16'd99);
		rom[26] = encI(`OP_SW, 0, 13, 16'd8);
		rom[27] = encI(`OP_LW, 0, 14, 16'd8);
		rom[28] = encR(14, 3, 15, `FN_SUBU);
		rom[29] = encI(`OP_SW, 0, 15, 16'd12);
		rom[30] = {`OP_J, 26'd30};
		// hand-worked results, word 0 of data memory starts as 32'h1357
		expReg = '{5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6, 5'd7, 5'd8, 5'd9, 5'd10, 5'd11,
			5'd12, 5'd13, 5'd14, 5'd15};
		expData = '{32'd5, 32'd8, 32'd13, 32'd8, 32'd8, 32'h1357, 32'h135C, 32'h135C,
			32'd7, 32'd5, 32'd1, 32'd104, 32'd92, 32'd92, 32'd79};
		expStAddr = '{32'd4, 32'd8, 32'd12};
		expStData = '{32'h135C, 32'd92, 32'd79};
		for (int pass = 0; pass < 2; pass++) begin
			@(negedge clk);
			waitsOn = pass[0];
			arstN = 1'b0;
			repeat (16) @(posedge clk);
			@(negedge clk);
			arstN = 1'b1;
			finishRegion("alu forwarding", 5, 0, pass);
			finishRegion("load-use", 8, 1, pass);
			finishRegion("branches", 11, 1, pass);
			finishRegion("j and jalr", 13, 1, pass);
			finishRegion("store and reload", numWb, numSt, pass);
		end
		$display("tests passed %0d failed %0d errors %0d", passed, failed, errors);
		if ((failed == 0) && (errors == 0)) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

/* vlog.f */
+incdir+common
common/pipePkg.sv
src/pipeReg.sv
src/regFile.sv
decode/decodeStage.sv
decode/hazardUnit.sv
src/executeStage.sv
src/pipelineTop.sv
dv/tbPipeline.sv

/* run.sh */
#!/bin/sh
# build and run the pipeline testbench with Verilator
set -e

verilator --binary --assert -f vlog.f --top-module tbPipeline -o simv
./obj_dir/simv > sim.log
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
	exit 1
fi
grep -q "PASS: all tests" sim.log
